// File: include/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath and address width
`define MIPS_DATA_W     32

// register address width, 32 registers
`define MIPS_REG_AW     5

`define MIPS_RESET_PC   32'h0000_0000 // fetch address out of reset

// all-ones word marks the end of a program
`define MIPS_HALT_WORD  32'hFFFF_FFFF

`endif

// File: design/mips_pkg.sv
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

    // primary opcodes, standard MIPS encodings
    typedef enum logic [5:0] {
        R_TYPE    = 6'b000000,
        J_TYPE    = 6'b000010,
        JAL_TYPE  = 6'b000011,
        BEQ_TYPE  = 6'b000100,
        BNE_TYPE  = 6'b000101,
        ADDI_TYPE = 6'b001000,
        ANDI_TYPE = 6'b001100,
        ORI_TYPE  = 6'b001101,
        LW_TYPE   = 6'b100011,
        SW_TYPE   = 6'b101011
    } opcode_e;

    // funct field of R-type words
    typedef enum logic [5:0] {
        JR   = 6'b001000,
        JALR = 6'b001001,
        ADD  = 6'b100000,
        SUB  = 6'b100010,
        AND  = 6'b100100,
        OR   = 6'b100101,
        SLT  = 6'b101010
    } funct_e;

    typedef enum logic [1:0] {
        RS_IDLE   = 2'd0,
        RS_RUN    = 2'd1,
        RS_HALTED = 2'd2
    } run_state_e;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'd0,
        ALU_SUB   = 2'd1,
        ALU_FUNCT = 2'd2, // execute looks at funct
        ALU_LOGIC = 2'd3
    } alu_op_e;

    typedef enum logic [1:0] {
        JK_NONE   = 2'd0,
        JK_BRANCH = 2'd1,
        JK_LINK   = 2'd2
    } jump_kind_e;

    typedef struct packed {
        logic       branch;
        logic       reg_dst;
        logic       mem2reg;
        logic       mem_read;
        logic       mem_write;
        logic       imm_flag;  // zero-extend the immediate
        logic       sign_flag;
        logic       reg_write;
        logic [1:0] alu_src;   // 01 selects the immediate
        alu_op_e    alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                    we;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_DATA_W-1:0] data;
    } wb_t;

    typedef struct packed {
        logic                    taken;
        logic [`MIPS_DATA_W-1:0] target;
        jump_kind_e              kind;
    } jump_t;

    typedef struct packed {
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
        logic [5:0]              opcode;
        logic [`MIPS_DATA_W-1:0] reg_da;
        logic [`MIPS_DATA_W-1:0] reg_db;
        logic [`MIPS_DATA_W-1:0] immediate;
        ctrl_t                   ctrl;
    } id_ex_t;

endpackage

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module register_file (
    input  wire                          clk,
    input  wire                          i_rst_n,
    input  wire  mips_pkg::wb_t          i_wb,
    input  wire  [`MIPS_REG_AW-1:0]      i_rd_addr1,
    input  wire  [`MIPS_REG_AW-1:0]      i_rd_addr2,
    output logic [`MIPS_DATA_W-1:0]      o_rd_data1,
    output logic [`MIPS_DATA_W-1:0]      o_rd_data2
);

    localparam int NUM_REGS = 1 << `MIPS_REG_AW;

    logic [`MIPS_DATA_W-1:0] regs [NUM_REGS];
    logic                    wr_valid;

    // r0 is hardwired, never written
    assign wr_valid = i_wb.we && (i_wb.addr != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // write-through so decode sees the value in the same cycle
    always_comb begin
        o_rd_data1 = regs[i_rd_addr1];
        o_rd_data2 = regs[i_rd_addr2];
        if (wr_valid && (i_wb.addr == i_rd_addr1)) o_rd_data1 = i_wb.data;
        if (wr_valid && (i_wb.addr == i_rd_addr2)) o_rd_data2 = i_wb.data;
    end

endmodule

`default_nettype wire

// File: design/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire  mips_pkg::opcode_e i_opcode,
    input  wire  mips_pkg::funct_e  i_funct,
    output mips_pkg::ctrl_t         o_ctrl,
    output logic                    o_jump_op,
    output logic                    o_link
);

    always_comb begin
        o_ctrl    = '0; // unknown codes fall through as a nop
        o_jump_op = 1'b0;
        o_link    = 1'b0;
        case (i_opcode)
            mips_pkg::R_TYPE: begin
                case (i_funct)
                    mips_pkg::ADD, mips_pkg::SUB, mips_pkg::AND,
                    mips_pkg::OR, mips_pkg::SLT: begin
                        o_ctrl.reg_dst   = 1'b1;
                        o_ctrl.reg_write = 1'b1;
                        o_ctrl.alu_op    = mips_pkg::ALU_FUNCT;
                    end
                    mips_pkg::JR: begin
                        o_jump_op = 1'b1; // no writeback
                    end
                    mips_pkg::JALR: begin
                        o_jump_op        = 1'b1;
                        o_link           = 1'b1;
                        o_ctrl.reg_dst   = 1'b1; // link goes to rd
                        o_ctrl.reg_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            mips_pkg::J_TYPE: begin
                o_jump_op = 1'b1;
            end
            mips_pkg::JAL_TYPE: begin
                o_jump_op        = 1'b1;
                o_link           = 1'b1;
                o_ctrl.reg_write = 1'b1; // rt is forced to r31
            end
            mips_pkg::BEQ_TYPE, mips_pkg::BNE_TYPE: begin
                o_ctrl.branch = 1'b1;
                o_ctrl.alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::ADDI_TYPE: begin
                o_ctrl.alu_src   = 2'b01;
                o_ctrl.sign_flag = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            mips_pkg::ANDI_TYPE, mips_pkg::ORI_TYPE: begin
                o_ctrl.imm_flag  = 1'b1; // logical ops zero-extend
                o_ctrl.alu_src   = 2'b01;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = mips_pkg::ALU_LOGIC;
            end
            mips_pkg::LW_TYPE: begin
                o_ctrl.mem_read  = 1'b1;
                o_ctrl.mem2reg   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 2'b01;
            end
            mips_pkg::SW_TYPE: begin
                o_ctrl.mem_write = 1'b1;
                o_ctrl.alu_src   = 2'b01;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module instruction_decode (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire  [`MIPS_DATA_W-1:0] i_instruction,
    input  wire  [`MIPS_DATA_W-1:0] i_pc,
    input  wire                     i_run,
    input  wire                     i_stall,
    input  wire  mips_pkg::wb_t     i_wb,
    output mips_pkg::id_ex_t        o_id_ex,
    output mips_pkg::jump_t         o_jump,
    output logic                    o_stop
);

    mips_pkg::opcode_e       opcode;
    mips_pkg::funct_e        funct;
    mips_pkg::ctrl_t         ctrl;
    mips_pkg::id_ex_t        id_ex_next;
    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    logic [`MIPS_REG_AW-1:0] rd;
    logic [15:0]             imm16;
    logic [`MIPS_DATA_W-1:0] ext_imm;
    logic [`MIPS_DATA_W-1:0] pc4;
    logic [`MIPS_DATA_W-1:0] rd_data1;
    logic [`MIPS_DATA_W-1:0] rd_data2;
    logic                    jump_op;
    logic                    link;
    logic                    br_cond;

    assign opcode = mips_pkg::opcode_e'(i_instruction[31:26]);
    assign funct  = mips_pkg::funct_e'(i_instruction[5:0]);
    assign rs     = i_instruction[25:21];
    assign rt     = i_instruction[20:16];
    assign rd     = i_instruction[15:11];
    assign imm16  = i_instruction[15:0];
    assign pc4    = i_pc + `MIPS_DATA_W'd4;

    // andi/ori zero-extend, everything else sign-extends
    assign ext_imm = ctrl.imm_flag ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    register_file u_regfile (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_wb       (i_wb),
        .i_rd_addr1 (rs),
        .i_rd_addr2 (rt),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2)
    );

    control_unit u_ctrl (
        .i_opcode  (opcode),
        .i_funct   (funct),
        .o_ctrl    (ctrl),
        .o_jump_op (jump_op),
        .o_link    (link)
    );

    // beq on equal, bne on differ
    assign br_cond = (opcode == mips_pkg::BEQ_TYPE) ? (rd_data1 == rd_data2)
                                                    : (rd_data1 != rd_data2);

    always_comb begin
        o_jump.taken  = 1'b0;
        o_jump.target = pc4;
        o_jump.kind   = mips_pkg::JK_NONE;
        if (jump_op) begin
            o_jump.taken = 1'b1;
            if (opcode == mips_pkg::R_TYPE)
                o_jump.target = rd_data1; // jr / jalr
            else
                o_jump.target = {pc4[31:28], i_instruction[25:0], 2'b00};
            if (link) o_jump.kind = mips_pkg::JK_LINK;
        end else if (ctrl.branch && br_cond) begin
            o_jump.taken  = 1'b1;
            o_jump.target = pc4 + (ext_imm << 2);
            o_jump.kind   = mips_pkg::JK_BRANCH;
        end
    end

    always_comb begin
        id_ex_next.rs        = link ? '0 : rs;
        id_ex_next.rt        = (opcode == mips_pkg::JAL_TYPE) ? 5'd31 : rt;
        id_ex_next.rd        = rd;
        id_ex_next.shamt     = i_instruction[10:6];
        id_ex_next.funct     = i_instruction[5:0];
        id_ex_next.opcode    = i_instruction[31:26];
        id_ex_next.reg_da    = link ? pc4 : rd_data1; // return address path
        id_ex_next.reg_db    = link ? `MIPS_DATA_W'd4 : rd_data2;
        id_ex_next.immediate = ext_imm;
        id_ex_next.ctrl      = i_stall ? '0 : ctrl; // bubble
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else if (i_run) begin
            o_id_ex <= id_ex_next;
        end
    end

    assign o_stop = (i_instruction == `MIPS_HALT_WORD);

endmodule

`default_nettype wire

// File: design/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module program_counter (
    input  wire                      clk,
    input  wire                      i_rst_n,
    input  wire                      i_run,
    input  wire                      i_stall,
    input  wire  mips_pkg::jump_t    i_jump,
    output logic [`MIPS_DATA_W-1:0]  o_pc
);

    logic advance;

    // idle, halted or stalled all hold the count
    assign advance = i_run && !i_stall;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= `MIPS_RESET_PC;
        end else if (advance) begin
            if (i_jump.taken)
                o_pc <= i_jump.target; // redirect from decode
            else
                o_pc <= o_pc + `MIPS_DATA_W'd4;
        end
    end

endmodule

`default_nettype wire

// File: design/run_control.sv
`timescale 1ns/1ps
`default_nettype none

module run_control (
    input  wire  clk,
    input  wire  i_rst_n,
    input  wire  i_start,
    input  wire  i_stop,
    output logic o_run,
    output logic o_halted
);

    mips_pkg::run_state_e state;
    mips_pkg::run_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            mips_pkg::RS_IDLE:   if (i_start) state_next = mips_pkg::RS_RUN;
            mips_pkg::RS_RUN:    if (i_stop) state_next = mips_pkg::RS_HALTED;
            mips_pkg::RS_HALTED: state_next = mips_pkg::RS_HALTED; // only reset leaves
            default:             state_next = mips_pkg::RS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= mips_pkg::RS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // drop run in the halt cycle itself, keeps the halt word out of id/ex
    assign o_run    = (state == mips_pkg::RS_RUN) && !i_stop;
    assign o_halted = (state == mips_pkg::RS_HALTED);

endmodule

`default_nettype wire

// File: design/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module decode_top (
    input  wire                      clk,
    input  wire                      i_rst_n,
    input  wire                      i_start,
    input  wire                      i_stall,
    input  wire  [`MIPS_DATA_W-1:0]  i_imem_data,
    input  wire  mips_pkg::wb_t      i_wb,
    output logic [`MIPS_DATA_W-1:0]  o_imem_addr,
    output logic [`MIPS_DATA_W-1:0]  o_pc,
    output mips_pkg::id_ex_t         o_id_ex,
    output mips_pkg::jump_t          o_jump,
    output logic                     o_halted
);

    logic run;
    logic stop; // halt word seen in decode

    run_control u_run_ctrl (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_stop   (stop),
        .o_run    (run),
        .o_halted (o_halted)
    );

    program_counter u_pc (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_run   (run),
        .i_stall (i_stall),
        .i_jump  (o_jump),
        .o_pc    (o_pc)
    );

    instruction_decode u_decode (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_instruction (i_imem_data),
        .i_pc          (o_pc),
        .i_run         (run),
        .i_stall       (i_stall),
        .i_wb          (i_wb),
        .o_id_ex       (o_id_ex),
        .o_jump        (o_jump),
        .o_stop        (stop)
    );

    assign o_imem_addr = o_pc; // fetch straight from the counter

endmodule

`default_nettype wire

// File: verif/tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module tb_decode_top;

    localparam int MAX_CYCLES = 400;

    logic                    clk;
    logic                    i_rst_n;
    logic                    i_start;
    logic                    i_stall;
    mips_pkg::wb_t           i_wb;
    logic [`MIPS_DATA_W-1:0] imem_addr;
    logic [`MIPS_DATA_W-1:0] imem_data;
    logic [`MIPS_DATA_W-1:0] o_pc;
    mips_pkg::id_ex_t        o_id_ex;
    mips_pkg::jump_t         o_jump;
    logic                    o_halted;

    logic [31:0] imem [64];
    logic [31:0] shadow [32]; // register contents as the testbench expects them
    logic [15:0] lfsr;
    int          errors;

    decode_top dut0 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_stall     (i_stall),
        .i_imem_data (imem_data),
        .i_wb        (i_wb),
        .o_imem_addr (imem_addr),
        .o_pc        (o_pc),
        .o_id_ex     (o_id_ex),
        .o_jump      (o_jump),
        .o_halted    (o_halted)
    );

    assign imem_data = imem[imem_addr[7:2]]; // word index, wraps every 64 words

    always #2 clk = ~clk;

    // once halted, nothing moves until reset
    halt_freeze: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_halted |=> (o_halted && (o_pc == $past(o_pc)) && (o_id_ex == $past(o_id_ex))))
        else begin
            errors++;
            $display("halted state changed after halt, o_pc now %h", o_pc);
        end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [5:0] pick_funct(input logic [2:0] n);
        case (n)
            3'd0:    return mips_pkg::ADD;
            3'd1:    return mips_pkg::SUB;
            3'd2:    return mips_pkg::AND;
            3'd3:    return mips_pkg::OR;
            default: return mips_pkg::SLT;
        endcase
    endfunction

    // control word per opcode, built flag by flag
    function automatic mips_pkg::ctrl_t expected_ctrl(input logic [5:0] op, input logic [5:0] fn);
        mips_pkg::ctrl_t c;
        logic            alu_r;
        c     = '0;
        alu_r = (op == mips_pkg::R_TYPE) && (fn inside {mips_pkg::ADD, mips_pkg::SUB,
                mips_pkg::AND, mips_pkg::OR, mips_pkg::SLT});
        if (alu_r) begin
            c.alu_op = mips_pkg::ALU_FUNCT;
        end
        if (alu_r || ((op == mips_pkg::R_TYPE) && (fn == mips_pkg::JALR))) begin
            c.reg_dst   = 1'b1;
            c.reg_write = 1'b1;
        end
        if (op inside {mips_pkg::JAL_TYPE, mips_pkg::ADDI_TYPE, mips_pkg::ANDI_TYPE,
                       mips_pkg::ORI_TYPE, mips_pkg::LW_TYPE}) c.reg_write = 1'b1;
        if (op inside {mips_pkg::BEQ_TYPE, mips_pkg::BNE_TYPE}) begin
            c.branch = 1'b1;
            c.alu_op = mips_pkg::ALU_SUB;
        end
        if (op inside {mips_pkg::ADDI_TYPE, mips_pkg::ANDI_TYPE, mips_pkg::ORI_TYPE,
                       mips_pkg::LW_TYPE, mips_pkg::SW_TYPE}) c.alu_src = 2'b01;
        if (op == mips_pkg::ADDI_TYPE) c.sign_flag = 1'b1;
        if (op inside {mips_pkg::ANDI_TYPE, mips_pkg::ORI_TYPE}) begin
            c.imm_flag = 1'b1; // zero extension
            c.alu_op   = mips_pkg::ALU_LOGIC;
        end
        c.mem_read  = (op == mips_pkg::LW_TYPE);
        c.mem2reg   = (op == mips_pkg::LW_TYPE);
        c.mem_write = (op == mips_pkg::SW_TYPE);
        return c;
    endfunction

    function automatic logic [31:0] read_reg(input logic [4:0] r, input mips_pkg::wb_t wb);
        if (r == 5'd0) return 32'd0;
        if (wb.we && (wb.addr == r)) return wb.data; // same-cycle bypass
        return shadow[r];
    endfunction

    task automatic check_value(input string name, input logic [159:0] exp_val,
                               input logic [159:0] act_val);
        assert (act_val === exp_val) else begin
            errors++;
            $display("[FAIL] %s expected %0h got %0h", name, exp_val, act_val);
        end
    endtask

    // one decode cycle, entered and left at posedge + 0.5 ns
    task automatic issue(input logic [31:0] word, input logic stall, input mips_pkg::wb_t wb);
        logic [5:0]           op;
        logic [5:0]           fn;
        logic [31:0]          pc;
        logic [31:0]          pc4;
        logic [31:0]          da;
        logic [31:0]          db;
        logic [31:0]          imm;
        logic [31:0]          target;
        logic                 is_link;
        logic                 taken;
        mips_pkg::jump_kind_e kind;
        mips_pkg::id_ex_t     exp;
        op      = word[31:26];
        fn      = word[5:0];
        pc      = o_pc;
        pc4     = pc + 32'd4;
        imem[pc[7:2]] = word;
        i_stall = stall;
        i_wb    = wb;
        da      = read_reg(word[25:21], wb);
        db      = read_reg(word[20:16], wb);
        is_link = (op == mips_pkg::JAL_TYPE) ||
                  ((op == mips_pkg::R_TYPE) && (fn == mips_pkg::JALR));
        imm     = (op inside {mips_pkg::ANDI_TYPE, mips_pkg::ORI_TYPE}) ?
                  {16'd0, word[15:0]} : {{16{word[15]}}, word[15:0]};
        taken   = 1'b0;
        target  = pc4;
        kind    = mips_pkg::JK_NONE;
        if (is_link || (op == mips_pkg::J_TYPE) ||
            ((op == mips_pkg::R_TYPE) && (fn == mips_pkg::JR))) begin
            taken  = 1'b1;
            target = (op == mips_pkg::R_TYPE) ? da : {pc4[31:28], word[25:0], 2'b00};
            kind   = is_link ? mips_pkg::JK_LINK : mips_pkg::JK_NONE;
        end else if (((op == mips_pkg::BEQ_TYPE) && (da == db)) ||
                     ((op == mips_pkg::BNE_TYPE) && (da != db))) begin
            taken  = 1'b1;
            target = pc4 + {imm[29:0], 2'b00};
            kind   = mips_pkg::JK_BRANCH;
        end
        exp.rs        = is_link ? 5'd0 : word[25:21];
        exp.rt        = (op == mips_pkg::JAL_TYPE) ? 5'd31 : word[20:16];
        exp.rd        = word[15:11];
        exp.shamt     = word[10:6];
        exp.funct     = fn;
        exp.opcode    = op;
        exp.reg_da    = is_link ? pc4 : da;
        exp.reg_db    = is_link ? 32'd4 : db;
        exp.immediate = imm;
        exp.ctrl      = stall ? '0 : expected_ctrl(op, fn);
        #1.5; // combinational jump is settled here
        check_value("o_imem_addr", 160'(pc), 160'(imem_addr));
        check_value("o_jump.taken", 160'(taken), 160'(o_jump.taken));
        check_value("o_jump.kind", 160'(kind), 160'(o_jump.kind));
        if (taken) check_value("o_jump.target", 160'(target), 160'(o_jump.target));
        @(posedge clk);
        if (wb.we && (wb.addr != 5'd0)) shadow[wb.addr] = wb.data;
        #0.5;
        check_value("o_id_ex", 160'(exp), 160'(o_id_ex));
        check_value("o_pc", 160'(stall ? pc : (taken ? target : pc4)), 160'(o_pc));
        check_value("o_halted", 160'(0), 160'(o_halted));
    endtask

    initial begin
        #((MAX_CYCLES * 4) + 200);
        $display("watchdog expired before the tests ended");
        $display("Test failed");
        $finish;
    end

    initial begin
        mips_pkg::wb_t    wb;
        mips_pkg::wb_t    no_wb;
        mips_pkg::id_ex_t idex_hold;
        logic [31:0]      rnd;
        logic [31:0]      word;
        logic [31:0]      pc_hold;
        logic [5:0]       op;
        clk     = 1'b0;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_stall = 1'b0;
        i_wb    = '0;
        no_wb   = '0;
        lfsr    = 16'd49014;
        errors  = 0;
        for (int i = 0; i < 64; i++) imem[i] = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        repeat (16) @(posedge clk);
        #0.5 i_rst_n = 1'b1;

        // idle holds the reset vector even with a jump in memory
        imem[0] = {mips_pkg::J_TYPE, 26'h000_0010};
        repeat (3) begin
            @(posedge clk);
            #0.5;
            check_value("o_pc", 160'(`MIPS_RESET_PC), 160'(o_pc));
            check_value("o_id_ex", 160'(0), 160'(o_id_ex));
        end
        i_start = 1'b1;
        @(posedge clk);
        #0.5 i_start = 1'b0;
        check_value("o_pc", 160'(`MIPS_RESET_PC), 160'(o_pc));

        // random alu, immediate and memory words over r0..r3 with random writeback
        repeat (40) begin
            rnd = rand_bits(32);
            case (3'(rand_bits(3)))
                3'd1:    op = mips_pkg::ADDI_TYPE;
                3'd2:    op = mips_pkg::ANDI_TYPE;
                3'd3:    op = mips_pkg::ORI_TYPE;
                3'd4:    op = mips_pkg::LW_TYPE;
                3'd5:    op = mips_pkg::SW_TYPE;
                default: op = mips_pkg::R_TYPE;
            endcase
            word = {op, 3'b000, rnd[22:21], 3'b000, rnd[17:16], rnd[15:0]};
            if (op == mips_pkg::R_TYPE) word[5:0] = pick_funct(3'(rand_bits(3)));
            wb.we   = 1'(rand_bits(1));
            wb.addr = 5'(rand_bits(2));
            wb.data = rand_bits(32);
            issue(word, 1'b0, wb);
        end

        // r0 ignores a write, even in the same cycle
        issue({mips_pkg::ADDI_TYPE, 5'd0, 5'd0, 16'h1234}, 1'b0, '{1'b1, 5'd0, 32'hDEAD_BEEF});

        // r1 == r2 != r3 for the branch cases
        rnd = rand_bits(32);
        issue({mips_pkg::ADDI_TYPE, 26'd0}, 1'b0, '{1'b1, 5'd1, rnd});
        issue({mips_pkg::ADDI_TYPE, 26'd0}, 1'b0, '{1'b1, 5'd2, rnd});
        issue({mips_pkg::ADDI_TYPE, 26'd0}, 1'b0, '{1'b1, 5'd3, ~rnd});
        issue({mips_pkg::BEQ_TYPE, 5'd1, 5'd2, 16'(rand_bits(8))}, 1'b0, no_wb);
        issue({mips_pkg::BEQ_TYPE, 5'd1, 5'd3, 16'h0005}, 1'b0, no_wb);
        issue({mips_pkg::BNE_TYPE, 5'd1, 5'd3, 16'hFFF8}, 1'b0, no_wb); // backwards
        issue({mips_pkg::BNE_TYPE, 5'd1, 5'd2, 16'h0007}, 1'b0, no_wb);

        // jumps, links and register jumps through r3
        issue({mips_pkg::J_TYPE, 26'(rand_bits(26))}, 1'b0, no_wb);
        issue({mips_pkg::JAL_TYPE, 26'(rand_bits(26))}, 1'b0, no_wb);
        issue({mips_pkg::ADDI_TYPE, 26'd0}, 1'b0, '{1'b1, 5'd3, {30'(rand_bits(30)), 2'b00}});
        issue({mips_pkg::R_TYPE, 5'd3, 15'd0, mips_pkg::JR}, 1'b0, no_wb);
        issue({mips_pkg::R_TYPE, 5'd3, 5'd0, 5'd31, 5'd0, mips_pkg::JALR}, 1'b0, no_wb);

        // stall makes bubbles, then the held word decodes normally
        word = {mips_pkg::ADDI_TYPE, 5'd1, 5'd2, 16'h8001};
        issue(word, 1'b1, no_wb);
        issue(word, 1'b1, no_wb);
        issue(word, 1'b0, no_wb);

        // halt and freeze
        pc_hold   = o_pc;
        idex_hold = o_id_ex;
        imem[pc_hold[7:2]] = `MIPS_HALT_WORD;
        i_wb = '0;
        repeat (10) begin
            @(posedge clk);
            #0.5;
            check_value("o_halted", 160'(1), 160'(o_halted));
            check_value("o_pc", 160'(pc_hold), 160'(o_pc));
            check_value("o_id_ex", 160'(idex_hold), 160'(o_id_ex));
            imem[pc_hold[7:2]] = rand_bits(32);
            i_start = 1'(rand_bits(1));
            i_stall = 1'(rand_bits(1));
        end

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
design/mips_pkg.sv
design/register_file.sv
design/control_unit.sv
design/instruction_decode.sv
design/program_counter.sv
design/run_control.sv
design/decode_top.sv
verif/tb_decode_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_decode_top -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation passed"
